//--- source/cpu_pkg.sv
////////////////////
// shared widths, memory sizes and encodings for the four-stage cpu
// memories are loaded in contiguous 16-word blocks from the host
// register 0 is an ordinary register with no hardwired zero
////////////////////
package cpu_pkg;

    localparam int word_w      = 32;
    localparam int reg_count   = 16;
    localparam int reg_idx_w   = 4;

    ////////////////////
    // memory geometry
    ////////////////////
    localparam int block_words = 16;
    localparam int word_idx_w  = $clog2(block_words);
    localparam int im_blocks   = 4;
    localparam int dm_blocks   = 2;
    localparam int im_words    = im_blocks * block_words;
    localparam int dm_words    = dm_blocks * block_words;
    localparam int im_idx_w    = $clog2(im_words);
    localparam int dm_idx_w    = $clog2(dm_words);
    localparam int blk_w       = im_idx_w - word_idx_w;

    localparam logic [blk_w-1:0]    dm_last_blk = blk_w'(dm_blocks - 1);
    localparam logic [blk_w-1:0]    im_last_blk = blk_w'(im_blocks - 1);
    localparam logic [im_idx_w-1:0] im_last_pc  = im_idx_w'(im_words - 1);

    localparam logic [word_w-1:0] block_bytes = 32'(block_words * 4);
    localparam logic [word_w-1:0] dm_base     = 32'h0000_1000;
    localparam logic [word_w-1:0] host_window = 32'h0000_9000; // stores from here go out
    localparam logic [word_w-1:0] im_space    = 32'h0001_0000; // flags instruction blocks

    typedef enum logic [1:0] {
        host_idle  = 2'd0,
        host_read  = 2'd1,
        host_write = 2'd3
    } host_op_t;

    ////////////////////
    // opcodes not listed here run as nop
    ////////////////////
    localparam logic [7:0] op_nop   = 8'h00;
    localparam logic [7:0] op_add   = 8'h01;
    localparam logic [7:0] op_sub   = 8'h02;
    localparam logic [7:0] op_and   = 8'h03;
    localparam logic [7:0] op_or    = 8'h04;
    localparam logic [7:0] op_addi  = 8'h11;
    localparam logic [7:0] op_load  = 8'h83;
    localparam logic [7:0] op_store = 8'h87;

    // loader states
    localparam logic [2:0] st_idle       = 3'd0;
    localparam logic [2:0] st_wait_data  = 3'd1;
    localparam logic [2:0] st_load_data  = 3'd2;
    localparam logic [2:0] st_wait_instr = 3'd3;
    localparam logic [2:0] st_load_instr = 3'd4;
    localparam logic [2:0] st_run        = 3'd5;
    localparam logic [2:0] st_write_host = 3'd6;

    // one instruction word, register and immediate views
    typedef union packed {
        struct packed {
            logic [7:0]  opcode;
            logic [3:0]  rd;
            logic [3:0]  rs;
            logic [3:0]  rt;
            logic [11:0] unused;
        } r_fmt;
        struct packed {
            logic [7:0]  opcode;
            logic [3:0]  rd;
            logic [3:0]  rs;
            logic [15:0] imm;    // sign-extended in decode
        } i_fmt;
    } instr_u;

endpackage

//--- source/host_loader.sv
////////////////////
// boot loader and host write port
// data blocks load first, then instruction blocks
// host may stall any request, tx_done closes each block or write
// hold stays high except in run
////////////////////
`timescale 1ns/1ps

module host_loader (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ready,
    input  logic                          rd_valid,
    input  logic                          tx_done,
    input  logic [cpu_pkg::word_w-1:0]    host_in_data,
    input  logic                          host_store,
    input  logic [cpu_pkg::word_w-1:0]    store_addr,
    input  logic [cpu_pkg::word_w-1:0]    store_data,
    output cpu_pkg::host_op_t             host_op,
    output logic [cpu_pkg::word_w-1:0]    host_addr,
    output logic [cpu_pkg::word_w-1:0]    host_out_data,
    output logic                          hold,
    output logic                          im_wr_en,
    output logic                          dm_wr_en,
    output logic [cpu_pkg::im_idx_w-1:0]  load_index,
    output logic [cpu_pkg::word_w-1:0]    load_data
);

    logic [2:0]                       state_q, state_d;
    logic [cpu_pkg::blk_w-1:0]        blk_q;
    logic [cpu_pkg::word_idx_w-1:0]   word_q;
    logic [cpu_pkg::word_w-1:0]       wr_addr_q, wr_data_q;
    logic [cpu_pkg::word_w-1:0]       blk_off;
    logic                             blk_done, last_blk;

    assign blk_off    = 32'(blk_q) * cpu_pkg::block_bytes;
    assign load_index = {blk_q, word_q};
    assign load_data  = host_in_data;
    assign hold       = (state_q != cpu_pkg::st_run);

    assign blk_done = tx_done && (state_q == cpu_pkg::st_load_data ||
                                  state_q == cpu_pkg::st_load_instr);
    assign last_blk = (state_q == cpu_pkg::st_load_data) ? (blk_q == cpu_pkg::dm_last_blk)
                                                         : (blk_q == cpu_pkg::im_last_blk);

    always_comb begin
        state_d       = state_q;
        host_op       = cpu_pkg::host_idle;
        host_addr     = '0;
        host_out_data = '0;
        im_wr_en      = 1'b0;
        dm_wr_en      = 1'b0;
        case (state_q)
            cpu_pkg::st_idle: begin
                if (ready)
                    state_d = cpu_pkg::st_wait_data;
            end
            cpu_pkg::st_wait_data: begin
                host_op   = cpu_pkg::host_read;
                host_addr = cpu_pkg::dm_base + blk_off;
                dm_wr_en  = rd_valid;           // word 0 comes with rd_valid
                if (rd_valid)
                    state_d = cpu_pkg::st_load_data;
            end
            cpu_pkg::st_load_data: begin
                host_op   = cpu_pkg::host_read;
                host_addr = cpu_pkg::dm_base + blk_off;
                dm_wr_en  = 1'b1;
                if (tx_done)
                    state_d = last_blk ? cpu_pkg::st_wait_instr : cpu_pkg::st_wait_data;
            end
            cpu_pkg::st_wait_instr: begin
                host_op   = cpu_pkg::host_read;
                host_addr = cpu_pkg::im_space + blk_off;
                im_wr_en  = rd_valid;
                if (rd_valid)
                    state_d = cpu_pkg::st_load_instr;
            end
            cpu_pkg::st_load_instr: begin
                host_op   = cpu_pkg::host_read;
                host_addr = cpu_pkg::im_space + blk_off;
                im_wr_en  = 1'b1;
                if (tx_done)
                    state_d = last_blk ? cpu_pkg::st_run : cpu_pkg::st_wait_instr;
            end
            cpu_pkg::st_run: begin
                if (host_store)
                    state_d = cpu_pkg::st_write_host;
            end
            cpu_pkg::st_write_host: begin
                host_op       = cpu_pkg::host_write;
                host_addr     = wr_addr_q;
                host_out_data = wr_data_q;
                if (tx_done)
                    state_d = cpu_pkg::st_run;
            end
            default: state_d = cpu_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= cpu_pkg::st_idle;
            blk_q   <= '0;
            word_q  <= '0;
        end else begin
            state_q <= state_d;
            if (blk_done)
                word_q <= '0;                   // early tx_done still realigns
            else if (im_wr_en || dm_wr_en)
                word_q <= word_q + 1'b1;
            if (blk_done)
                blk_q <= last_blk ? '0 : blk_q + 1'b1;
        end
    end

    // address and data of the pending host write
    always_ff @(posedge clk) begin
        if (state_q == cpu_pkg::st_run && host_store) begin
            wr_addr_q <= store_addr;
            wr_data_q <= store_data;
        end
    end

endmodule

//--- source/fetch_stage.sv
////////////////////
// pc and instruction memory
// pc is the address of the word now in decode
// no branches, pc parks on the last word
////////////////////
`timescale 1ns/1ps

module fetch_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          hold,
    input  logic                          stall,
    input  logic                          im_wr_en,
    input  logic [cpu_pkg::im_idx_w-1:0]  load_index,
    input  logic [cpu_pkg::word_w-1:0]    load_data,
    output cpu_pkg::instr_u               instr
);

    logic [cpu_pkg::word_w-1:0]   im_mem [cpu_pkg::im_words];
    logic [cpu_pkg::im_idx_w-1:0] pc, rd_addr;
    logic                         advance;

    assign advance = !hold && !stall && (pc != cpu_pkg::im_last_pc);

    // under stall the same word is read again and stays in decode,
    // decode turns it into a bubble for execute
    assign rd_addr = advance ? pc + 1'b1 : pc;

    // boot write port
    always_ff @(posedge clk) begin
        if (im_wr_en)
            im_mem[load_index] <= load_data;
    end

    ////////////////////
    // synchronous read
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= '0;
            instr <= '0;                        // nop
        end else begin
            pc    <= rd_addr;
            instr <= im_mem[rd_addr];           // keeps refreshing word 0 during boot
        end
    end

endmodule

//--- source/decode_stage.sv
////////////////////
// decode, register file and hazard check
// without bypass an instruction waits until its producer has written back
// stores read rd as their data register
////////////////////
`timescale 1ns/1ps

module decode_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           hold,
    input  cpu_pkg::instr_u                instr,
    input  logic                           wb_en,
    input  logic [cpu_pkg::reg_idx_w-1:0]  wb_reg,
    input  logic [cpu_pkg::word_w-1:0]     wb_data,
    input  logic                           mem_wr,
    input  logic [cpu_pkg::reg_idx_w-1:0]  mem_rd,
    input  logic                           wb_pending,
    input  logic [cpu_pkg::reg_idx_w-1:0]  wb_pend_rd,
    output logic                           stall,
    output logic                           ex_valid_wr,
    output logic [cpu_pkg::reg_idx_w-1:0]  ex_rd,
    output logic [cpu_pkg::word_w-1:0]     ex_a,
    output logic [cpu_pkg::word_w-1:0]     ex_b,
    output logic [cpu_pkg::word_w-1:0]     ex_imm,
    output logic [7:0]                     ex_opcode
);

    logic [cpu_pkg::word_w-1:0]    regs [cpu_pkg::reg_count];
    logic [cpu_pkg::reg_count-1:0] busy;
    logic [cpu_pkg::reg_idx_w-1:0] b_sel;
    logic [7:0]                    opcode;
    logic                          uses_rs, uses_b, writes_reg;

    assign opcode = instr.r_fmt.opcode;

    always_comb begin
        uses_rs    = 1'b0;
        uses_b     = 1'b0;
        writes_reg = 1'b0;
        b_sel      = instr.r_fmt.rt;
        case (opcode)
            cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_or: begin
                uses_rs    = 1'b1;
                uses_b     = 1'b1;
                writes_reg = 1'b1;
            end
            cpu_pkg::op_addi, cpu_pkg::op_load: begin
                uses_rs    = 1'b1;
                writes_reg = 1'b1;
            end
            cpu_pkg::op_store: begin
                uses_rs = 1'b1;
                uses_b  = 1'b1;
                b_sel   = instr.i_fmt.rd;       // store data
            end
            default: ;
        endcase
    end

    ////////////////////
    // registers still owed by execute, memory and writeback
    ////////////////////
    always_comb begin
        busy = '0;
        if (ex_valid_wr)
            busy[ex_rd] = 1'b1;
        if (mem_wr)
            busy[mem_rd] = 1'b1;
        if (wb_pending)
            busy[wb_pend_rd] = 1'b1;
    end

    assign stall = (uses_rs && busy[instr.r_fmt.rs]) || (uses_b && busy[b_sel]);

    // register file is written one edge after the writeback register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_pkg::reg_count; i++)
                regs[i] <= '0;
        end else if (wb_en) begin
            regs[wb_reg] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid_wr <= 1'b0;
            ex_rd       <= '0;
            ex_opcode   <= cpu_pkg::op_nop;
        end else if (!hold) begin
            ex_valid_wr <= writes_reg && !stall;
            ex_rd       <= instr.r_fmt.rd;
            ex_opcode   <= stall ? cpu_pkg::op_nop : opcode;   // bubble
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            ex_a   <= regs[instr.r_fmt.rs];
            ex_b   <= regs[b_sel];
            ex_imm <= {{16{instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
        end
    end

endmodule

//--- source/execute_stage.sv
////////////////////
// alu and execute/memory register
// loads and stores form their address with the adder
////////////////////
`timescale 1ns/1ps

module execute_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           hold,
    input  logic                           ex_valid_wr,
    input  logic [cpu_pkg::reg_idx_w-1:0]  ex_rd,
    input  logic [cpu_pkg::word_w-1:0]     ex_a,
    input  logic [cpu_pkg::word_w-1:0]     ex_b,
    input  logic [cpu_pkg::word_w-1:0]     ex_imm,
    input  logic [7:0]                     ex_opcode,
    output logic                           mem_wr,
    output logic [cpu_pkg::reg_idx_w-1:0]  mem_rd,
    output logic [7:0]                     mem_opcode,
    output logic [cpu_pkg::word_w-1:0]     alu_out,
    output logic [cpu_pkg::word_w-1:0]     st_data
);

    logic [cpu_pkg::word_w-1:0] b_op, result;
    logic                       use_imm;

    assign use_imm = (ex_opcode == cpu_pkg::op_addi) || (ex_opcode == cpu_pkg::op_load) ||
                     (ex_opcode == cpu_pkg::op_store);
    assign b_op    = use_imm ? ex_imm : ex_b;

    always_comb begin
        case (ex_opcode)
            cpu_pkg::op_sub: result = ex_a - b_op;
            cpu_pkg::op_and: result = ex_a & b_op;
            cpu_pkg::op_or:  result = ex_a | b_op;
            default:         result = ex_a + b_op;  // add, addi, address
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wr     <= 1'b0;
            mem_rd     <= '0;
            mem_opcode <= cpu_pkg::op_nop;
        end else if (!hold) begin
            mem_wr     <= ex_valid_wr;
            mem_rd     <= ex_rd;
            mem_opcode <= ex_opcode;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            alu_out <= result;
            st_data <= ex_b;
        end
    end

endmodule

//--- source/memory_stage.sv
////////////////////
// data memory and memory/writeback register
// word index wraps modulo the memory size
// stores at or above the host window bypass the data memory
////////////////////
`timescale 1ns/1ps

module memory_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           hold,
    input  logic                           mem_wr,
    input  logic [cpu_pkg::reg_idx_w-1:0]  mem_rd,
    input  logic [7:0]                     mem_opcode,
    input  logic [cpu_pkg::word_w-1:0]     alu_out,
    input  logic [cpu_pkg::word_w-1:0]     st_data,
    input  logic                           dm_wr_en,
    input  logic [cpu_pkg::im_idx_w-1:0]   load_index,
    input  logic [cpu_pkg::word_w-1:0]     load_data,
    output logic                           host_store,
    output logic [cpu_pkg::word_w-1:0]     store_addr,
    output logic [cpu_pkg::word_w-1:0]     store_data,
    output logic                           wb_en,
    output logic [cpu_pkg::reg_idx_w-1:0]  wb_reg,
    output logic [cpu_pkg::word_w-1:0]     wb_data
);

    logic [cpu_pkg::word_w-1:0]   dm_mem [cpu_pkg::dm_words];
    logic [cpu_pkg::dm_idx_w-1:0] dm_idx;
    logic                         is_store, to_host;

    assign dm_idx   = alu_out[2 +: cpu_pkg::dm_idx_w];  // byte address to word
    assign is_store = (mem_opcode == cpu_pkg::op_store);
    assign to_host  = is_store && (alu_out >= cpu_pkg::host_window);

    // one pulse per store, the loader raises hold right after
    assign host_store = to_host && !hold;
    assign store_addr = alu_out;
    assign store_data = st_data;

    always_ff @(posedge clk) begin
        if (dm_wr_en)
            dm_mem[load_index[cpu_pkg::dm_idx_w-1:0]] <= load_data;
        else if (is_store && !to_host && !hold)
            dm_mem[dm_idx] <= st_data;
    end

    ////////////////////
    // writeback register
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en  <= 1'b0;
            wb_reg <= '0;
        end else if (!hold) begin
            wb_en  <= mem_wr;
            wb_reg <= mem_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold)
            wb_data <= (mem_opcode == cpu_pkg::op_load) ? dm_mem[dm_idx] : alu_out;
    end

endmodule

//--- source/cpu_top.sv
////////////////////
// four-stage cpu with host boot and host write port
// holds until all blocks are loaded
////////////////////
`timescale 1ns/1ps

module cpu_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ready,
    input  logic                        rd_valid,
    input  logic                        tx_done,
    input  logic [cpu_pkg::word_w-1:0]  host_in_data,
    output cpu_pkg::host_op_t           host_op,
    output logic [cpu_pkg::word_w-1:0]  host_addr,
    output logic [cpu_pkg::word_w-1:0]  host_out_data
);

    logic                          hold, stall;
    logic                          im_wr_en, dm_wr_en;
    logic [cpu_pkg::im_idx_w-1:0]  load_index;
    logic [cpu_pkg::word_w-1:0]    load_data;
    logic                          host_store;
    logic [cpu_pkg::word_w-1:0]    store_addr, store_data;
    cpu_pkg::instr_u               instr;

    // decode to execute
    logic                          ex_valid_wr;
    logic [cpu_pkg::reg_idx_w-1:0] ex_rd;
    logic [cpu_pkg::word_w-1:0]    ex_a, ex_b, ex_imm;
    logic [7:0]                    ex_opcode;

    // execute to memory
    logic                          mem_wr;
    logic [cpu_pkg::reg_idx_w-1:0] mem_rd;
    logic [7:0]                    mem_opcode;
    logic [cpu_pkg::word_w-1:0]    alu_out, st_data;

    // writeback
    logic                          wb_en;
    logic [cpu_pkg::reg_idx_w-1:0] wb_reg;
    logic [cpu_pkg::word_w-1:0]    wb_data;

    host_loader u_loader (
        .clk(clk), .rst_n(rst_n), .ready(ready), .rd_valid(rd_valid), .tx_done(tx_done),
        .host_in_data(host_in_data), .host_store(host_store), .store_addr(store_addr),
        .store_data(store_data), .host_op(host_op), .host_addr(host_addr),
        .host_out_data(host_out_data), .hold(hold), .im_wr_en(im_wr_en),
        .dm_wr_en(dm_wr_en), .load_index(load_index), .load_data(load_data)
    );

    fetch_stage u_fetch (
        .clk(clk), .rst_n(rst_n), .hold(hold), .stall(stall), .im_wr_en(im_wr_en),
        .load_index(load_index), .load_data(load_data), .instr(instr)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n), .hold(hold), .instr(instr), .wb_en(wb_en),
        .wb_reg(wb_reg), .wb_data(wb_data), .mem_wr(mem_wr), .mem_rd(mem_rd),
        .wb_pending(wb_en), .wb_pend_rd(wb_reg), .stall(stall),
        .ex_valid_wr(ex_valid_wr), .ex_rd(ex_rd), .ex_a(ex_a), .ex_b(ex_b),
        .ex_imm(ex_imm), .ex_opcode(ex_opcode)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n(rst_n), .hold(hold), .ex_valid_wr(ex_valid_wr), .ex_rd(ex_rd),
        .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm), .ex_opcode(ex_opcode),
        .mem_wr(mem_wr), .mem_rd(mem_rd), .mem_opcode(mem_opcode),
        .alu_out(alu_out), .st_data(st_data)
    );

    memory_stage u_memory (
        .clk(clk), .rst_n(rst_n), .hold(hold), .mem_wr(mem_wr), .mem_rd(mem_rd),
        .mem_opcode(mem_opcode), .alu_out(alu_out), .st_data(st_data),
        .dm_wr_en(dm_wr_en), .load_index(load_index), .load_data(load_data),
        .host_store(host_store), .store_addr(store_addr), .store_data(store_data),
        .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
    );

endmodule

//--- sim/cpu_assert.sv
////////////////////
// concurrent checks on the host port and pipeline hold
// bound into cpu_top, pc is taken from the fetch stage
////////////////////
`timescale 1ns/1ps

module cpu_assert (
    input logic                          clk,
    input logic                          rst_n,
    input cpu_pkg::host_op_t             host_op,
    input logic [cpu_pkg::word_w-1:0]    host_addr,
    input logic [cpu_pkg::word_w-1:0]    host_out_data,
    input logic                          tx_done,
    input logic                          hold,
    input logic [cpu_pkg::im_idx_w-1:0]  pc
);

    idle_in_reset: assert property (@(posedge clk) !rst_n |-> host_op == cpu_pkg::host_idle)
        else $error("host_op not idle during reset");

    // a pending write keeps op, address and data until tx_done
    write_steady: assert property (@(posedge clk) disable iff (!rst_n)
        (host_op == cpu_pkg::host_write && !tx_done) |=>
        (host_op == cpu_pkg::host_write && $stable(host_addr) && $stable(host_out_data)))
        else $error("host write changed before tx_done");

    pc_frozen: assert property (@(posedge clk) disable iff (!rst_n) hold |=> $stable(pc))
        else $error("pc moved while hold was high");

endmodule

bind cpu_top cpu_assert u_assert (
    .clk(clk), .rst_n(rst_n), .host_op(host_op), .host_addr(host_addr),
    .host_out_data(host_out_data), .tx_done(tx_done), .hold(hold), .pc(u_fetch.pc)
);

//--- sim/cpu_tb.sv
////////////////////
// testbench for cpu_top with a behavioral host
// boot image and expected host writes come from sim/cpu_tests.txt
// host answers each request after 0 to max_delay idle cycles
// inputs change on the falling edge, outputs are sampled there too
// the run stops at the first wrong value
////////////////////
`timescale 1ns/1ps

module cpu_tb;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        ready;
    logic                        rd_valid;
    logic                        tx_done;
    logic [cpu_pkg::word_w-1:0]  host_in_data;
    cpu_pkg::host_op_t           host_op;
    logic [cpu_pkg::word_w-1:0]  host_addr;
    logic [cpu_pkg::word_w-1:0]  host_out_data;

    logic [cpu_pkg::word_w-1:0]  tests_mem [0:127];    // boot image, count, pairs
    integer                      seed = 32'hc8d4_c7ae;
    int                          max_delay = 7;         // used as a mask
    int                          total_blocks = cpu_pkg::dm_blocks + cpu_pkg::im_blocks;
    int                          count_idx = cpu_pkg::dm_words + cpu_pkg::im_words;
    int                          n_writes;
    int                          blocks_seen = 0;
    int                          writes_seen = 0;

    cpu_top dut (
        .clk(clk), .rst_n(rst_n), .ready(ready), .rd_valid(rd_valid), .tx_done(tx_done),
        .host_in_data(host_in_data), .host_op(host_op), .host_addr(host_addr),
        .host_out_data(host_out_data)
    );

    always #5 clk = ~clk;

    function automatic logic [cpu_pkg::word_w-1:0] test_word(input int idx);
        return tests_mem[7'(idx)];
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    ////////////////////
    // host model
    ////////////////////
    task automatic serve_read();
        logic [cpu_pkg::word_w-1:0] exp_addr;
        int                         delay;
        int                         w;
        if (blocks_seen >= total_blocks)
            abort_run("read request after the last boot block");
        if (blocks_seen < cpu_pkg::dm_blocks)
            exp_addr = cpu_pkg::dm_base + 32'(blocks_seen) * cpu_pkg::block_bytes;
        else
            exp_addr = cpu_pkg::im_space +
                       32'(blocks_seen - cpu_pkg::dm_blocks) * cpu_pkg::block_bytes;
        compare_value("host_addr", host_addr, exp_addr);
        delay = $random(seed) & max_delay;
        repeat (delay) @(negedge clk);
        for (w = 0; w < cpu_pkg::block_words; w++) begin
            host_in_data = test_word(blocks_seen * cpu_pkg::block_words + w);
            rd_valid     = (w == 0);
            tx_done      = (w == cpu_pkg::block_words - 1);   // last word closes the block
            @(negedge clk);
        end
        rd_valid     = 1'b0;
        tx_done      = 1'b0;
        host_in_data = '0;
        blocks_seen++;
    endtask

    task automatic serve_write();
        int delay;
        if (writes_seen >= n_writes)
            abort_run("host write seen after the last expected one");
        compare_value("host_addr", host_addr, test_word(count_idx + 1 + 2 * writes_seen));
        compare_value("host_out_data", host_out_data,
                      test_word(count_idx + 2 + 2 * writes_seen));
        writes_seen++;
        delay = $random(seed) & max_delay;
        repeat (delay) @(negedge clk);
        tx_done = 1'b1;
        @(negedge clk);
        tx_done = 1'b0;
    endtask

    initial begin
        rd_valid     = 1'b0;
        tx_done      = 1'b0;
        host_in_data = '0;
        @(posedge rst_n);
        @(negedge clk);
        forever begin
            if (host_op == cpu_pkg::host_read)
                serve_read();
            else if (host_op == cpu_pkg::host_write)
                serve_write();
            else
                @(negedge clk);
        end
    end

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        rst_n = 1'b0;
        ready = 1'b0;
        $readmemh("sim/cpu_tests.txt", tests_mem);
        n_writes = int'(test_word(count_idx));
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (8) begin                            // quiet port before ready
            @(negedge clk);
            compare_value("host_op", 32'(host_op), 32'(cpu_pkg::host_idle));
            compare_value("host_addr", host_addr, 32'h0);
        end
        ready = 1'b1;
        wait (writes_seen == n_writes);
        repeat (200) @(negedge clk);                // room for a stray extra write
        $display("TEST OK");
        $finish;
    end

    initial begin : watchdog
        int limit;
        @(posedge rst_n);
        limit = (total_blocks * 64 + n_writes * 200) * (max_delay + 1) + 400;
        repeat (limit) @(posedge clk);
        abort_run("watchdog expired before all host writes were seen");
    end

endmodule

//--- sim/cpu_tests.txt
// boot image in request order, 32 data words then 64 instruction words, eight per line
// at 0x60 the number of expected host writes, then one address/value pair per line
@00
0f0f1234 00ff00f1 d0000002 d0000003 d0000004 d0000005 d0000006 d0000007
d0000008 d0000009 d000000a d000000b d000000c d000000d d000000e cafe0015
d0000010 d0000011 d0000012 d0000013 d0000014 d0000015 d0000016 d0000017
d0000018 d0000019 d000001a d000001b d000001c d000001d d000001e beef0031
@20
11e04800 01eee000 11d01000 831d0000 832d0004 01312000 873e0000 02412000
874e0004 03512000 875e0008 04612000 876e000c 1171fffd 877e0010 01812000
01881000 02882000 04883000 878e0014 01912000 00000000 00000000 00000000
01991000 00000000 00000000 00000000 02992000 00000000 00000000 00000000
04993000 00000000 00000000 00000000 879e0018 83ad003c 87ad0040 83bd0040
87be001c 83cd007c 87ce0020 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
@60
00000009
00009000 100e1325
00009004 0e101143
00009008 000f0030
0000900c 0fff12f5
00009010 0f0f1231
00009014 1e1e376d
00009018 1e1e376d
0000901c cafe0015
00009020 beef0031

//--- files.f
source/cpu_pkg.sv
source/host_loader.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu_top.sv
sim/cpu_assert.sv
sim/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the cpu testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --assert -f files.f --top-module cpu_tb -o cpu_sim
status=0
./obj_dir/cpu_sim > sim.log 2>&1 || status=$?
cat sim.log
if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, exit status $status"
    exit 1
fi
